// File: hw/rot_pkg.sv
package rot_pkg;

   // frame geometry, fixed at 16 x 16.
   localparam int FRAME_COLS   = 16;
   localparam int FRAME_ROWS   = 16;
   localparam int COL_BITS     = 4;
   localparam int ROW_BITS     = 4;
   localparam int FRAME_PIXELS = FRAME_COLS * FRAME_ROWS;
   localparam int PIX_ADDR_W   = COL_BITS + ROW_BITS;

   localparam int PIXEL_WIDTH  = 10; // input sample width.
   localparam int BYTE_W       = 8;  // stored sample width.
   localparam int META_WIDTH   = 16;
   localparam int DTYPE_WIDTH  = 4;

   typedef enum logic [DTYPE_WIDTH-1:0] {
      DTYPE_IDLE        = 4'd0,
      DTYPE_FRAME_START = 4'd1,
      DTYPE_PIXEL       = 4'd2,
      DTYPE_HEADER      = 4'd3
   } dtype_e;

   localparam logic [15:0] TERM_ROTATE = 16'h0010;

   typedef enum logic [31:0] {
      REG_CTRL   = 32'd0, // bit 0 enable_rotate, bit 1 enable_420.
      REG_SIN    = 32'd1,
      REG_COS    = 32'd2,
      REG_FRAMES = 32'd3  // read only.
   } reg_e;

   // sine and cosine are signed q1.8.
   localparam int ANGLE_WIDTH = 10;
   localparam int ANGLE_ONE   = 256;
   localparam logic signed [ANGLE_WIDTH-1:0] COS_RESET = ANGLE_WIDTH'(ANGLE_ONE);

   // rotation arithmetic on doubled centre-relative coordinates.
   localparam int ROT_PROD_W = ANGLE_WIDTH + COL_BITS + 2;
   localparam int ROT_SUM_W  = ROT_PROD_W + 1;
   localparam int ROT_SHIFT  = 9;                       // 2 * ANGLE_ONE.
   localparam int ROT_BIAS   = FRAME_COLS * ANGLE_ONE;  // centre plus half a pixel.

   localparam logic [BYTE_W-1:0] BLACK_Y = 8'd16;
   localparam logic [BYTE_W-1:0] BLACK_C = 8'd128;

endpackage

// File: hw/pix_if.sv
interface pix_if import rot_pkg::*; #(
   parameter int W = PIXEL_WIDTH
) ();

   logic                  dv;    // one beat per cycle while high.
   dtype_e                dtype;
   logic [W-1:0]          y;
   logic [W-1:0]          u;
   logic [W-1:0]          v;
   logic [META_WIDTH-1:0] meta;

   modport src (
      output dv, dtype, y, u, v, meta
   );

   modport snk (
      input dv, dtype, y, u, v, meta
   );

endinterface

// File: hw/rot_cfg_if.sv
interface rot_cfg_if import rot_pkg::*; ();

   logic                          enable_rotate;
   logic                          enable_420;
   logic signed [ANGLE_WIDTH-1:0] sin_theta;
   logic signed [ANGLE_WIDTH-1:0] cos_theta;
   logic                          frame_start; // reloads the shadow copies.

   modport ctl (
      output enable_rotate, enable_420, sin_theta, cos_theta,
      input  frame_start
   );

   modport user (
      input  enable_rotate, enable_420, sin_theta, cos_theta,
      output frame_start
   );

endinterface

// File: hw/reg_terminal.sv
module reg_terminal import rot_pkg::*; (
   input  logic        img_clk,
   input  logic        rst_n,
   input  logic [15:0] di_term_addr,
   input  logic [31:0] di_reg_addr,
   input  logic        di_read,
   input  logic        di_write,
   input  logic [31:0] di_reg_datai,
   output logic        di_read_rdy,
   output logic [31:0] di_reg_datao,
   output logic        di_write_rdy,
   output logic [15:0] di_transfer_status,
   output logic        di_en,
   rot_cfg_if.ctl      cfg
);

   logic                          hit;
   logic                          enable_rotate;
   logic                          enable_420;
   logic signed [ANGLE_WIDTH-1:0] sin_theta;
   logic signed [ANGLE_WIDTH-1:0] cos_theta;
   logic [31:0]                   frame_cnt;
   logic [31:0]                   rd_data;

   assign hit = (di_term_addr == TERM_ROTATE);

   // working copies, written from the bus at any time.
   always_ff @(posedge img_clk or negedge rst_n) begin
      if (!rst_n) begin
         enable_rotate <= 1'b0;
         enable_420    <= 1'b0;
         sin_theta     <= '0;
         cos_theta     <= COS_RESET;
      end else if (di_write && hit) begin
         case (di_reg_addr)
            REG_CTRL: begin
               enable_rotate <= di_reg_datai[0];
               enable_420    <= di_reg_datai[1];
            end
            REG_SIN: sin_theta <= di_reg_datai[ANGLE_WIDTH-1:0];
            REG_COS: cos_theta <= di_reg_datai[ANGLE_WIDTH-1:0];
            default: ;
         endcase
      end
   end

   // shadow copies seen by the pipeline change only at a frame start.
   always_ff @(posedge img_clk or negedge rst_n) begin
      if (!rst_n) begin
         cfg.enable_rotate <= 1'b0;
         cfg.enable_420    <= 1'b0;
         cfg.sin_theta     <= '0;
         cfg.cos_theta     <= COS_RESET;
         frame_cnt         <= '0;
      end else if (cfg.frame_start) begin
         cfg.enable_rotate <= enable_rotate;
         cfg.enable_420    <= enable_420;
         cfg.sin_theta     <= sin_theta;
         cfg.cos_theta     <= cos_theta;
         frame_cnt         <= frame_cnt + 1'b1;
      end
   end

   always_comb begin
      case (di_reg_addr)
         REG_CTRL:   rd_data = {30'd0, enable_420, enable_rotate};
         REG_SIN:    rd_data = 32'(sin_theta); // sign extended.
         REG_COS:    rd_data = 32'(cos_theta);
         REG_FRAMES: rd_data = frame_cnt;
         default:    rd_data = 32'd0;
      endcase
   end

   assign di_read_rdy        = 1'b1;
   assign di_write_rdy       = 1'b1;
   assign di_en              = hit;
   assign di_transfer_status = hit ? 16'd0 : 16'd1;
   assign di_reg_datao       = (hit && di_read) ? rd_data : 32'd0; // bus idles at zero.

endmodule

// File: hw/uv_offset.sv
module uv_offset import rot_pkg::*; (
   input logic img_clk,
   input logic rst_n,
   input logic enable,
   pix_if.snk  in,
   pix_if.src  out
);

   logic [PIXEL_WIDTH-1:0] u_off;
   logic [PIXEL_WIDTH-1:0] v_off;

   // adding half scale to a two's complement sample just flips the msb.
   assign u_off = enable ? {~in.u[PIXEL_WIDTH-1], in.u[PIXEL_WIDTH-2:0]} : in.u;
   assign v_off = enable ? {~in.v[PIXEL_WIDTH-1], in.v[PIXEL_WIDTH-2:0]} : in.v;

   always_ff @(posedge img_clk or negedge rst_n) begin
      if (!rst_n) begin
         out.dv    <= 1'b0;
         out.dtype <= DTYPE_IDLE;
      end else begin
         out.dv    <= in.dv;
         out.dtype <= in.dv ? in.dtype : DTYPE_IDLE;
      end
   end

   always_ff @(posedge img_clk) begin
      out.y    <= in.y;  // luma untouched.
      out.u    <= u_off;
      out.v    <= v_off;
      out.meta <= in.meta;
   end

endmodule

// File: hw/rotate_buffer.sv
module rotate_buffer import rot_pkg::*; (
   input logic     img_clk,
   input logic     rst_n,
   pix_if.snk      in,
   pix_if.src      out,
   rot_cfg_if.user cfg
);

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_HEADER,
      RD_PIXELS
   } rd_state_e;

   logic [3*BYTE_W-1:0] bank_mem [2][FRAME_PIXELS];

   logic                  wr_bank;
   logic [PIX_ADDR_W-1:0] wr_addr;
   logic [META_WIDTH-1:0] wr_meta;
   logic                  wr_pixel;
   logic                  wr_last;

   rd_state_e                     rd_state;
   logic                          rd_bank;
   logic [PIX_ADDR_W-1:0]         rd_pos;
   logic [META_WIDTH-1:0]         rd_meta;
   logic                          rd_rot;
   logic signed [ANGLE_WIDTH-1:0] rd_sin;
   logic signed [ANGLE_WIDTH-1:0] rd_cos;
   logic signed [COL_BITS+1:0]    dx;
   logic signed [ROW_BITS+1:0]    dy;

   logic                         s1_dv;
   dtype_e                       s1_dtype;
   logic [PIX_ADDR_W-1:0]        s1_pos;
   logic                         s1_bank;
   logic                         s1_rot;
   logic signed [ROT_PROD_W-1:0] s1_cx;
   logic signed [ROT_PROD_W-1:0] s1_sy;
   logic signed [ROT_PROD_W-1:0] s1_sx;
   logic signed [ROT_PROD_W-1:0] s1_cy;
   logic signed [ROT_SUM_W-1:0]  sum_x;
   logic signed [ROT_SUM_W-1:0]  sum_y;
   logic                         in_frame;

   logic                  s2_dv;
   dtype_e                s2_dtype;
   logic                  s2_bank;
   logic [PIX_ADDR_W-1:0] s2_addr;
   logic                  s2_inside;

   logic [3*BYTE_W-1:0] rd_word;
   logic                s3_inside;

   assign wr_pixel        = in.dv && (in.dtype == DTYPE_PIXEL);
   assign wr_last         = wr_pixel && (wr_addr == PIX_ADDR_W'(FRAME_PIXELS - 1));
   assign cfg.frame_start = in.dv && (in.dtype == DTYPE_FRAME_START);

   always_ff @(posedge img_clk) begin
      if (wr_pixel)
         bank_mem[wr_bank][wr_addr] <= {in.y[PIXEL_WIDTH-1 -: BYTE_W],
                                        in.u[PIXEL_WIDTH-1 -: BYTE_W],
                                        in.v[PIXEL_WIDTH-1 -: BYTE_W]};
   end

   always_ff @(posedge img_clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_bank  <= 1'b0;
         wr_addr  <= '0;
         rd_state <= RD_IDLE;
         rd_bank  <= 1'b0;
         rd_pos   <= '0;
         rd_rot   <= 1'b0;
         rd_sin   <= '0;
         rd_cos   <= COS_RESET;
      end else begin
         if (cfg.frame_start)
            wr_addr <= '0;
         else if (wr_pixel)
            wr_addr <= wr_addr + 1'b1;

         if (rd_state == RD_PIXELS)
            rd_pos <= rd_pos + 1'b1; // wraps back to 0 after the last pixel.

         // a full bank swaps in and the read side takes its own copy of the controls.
         if (wr_last) begin
            wr_bank  <= ~wr_bank;
            rd_bank  <= wr_bank;
            rd_rot   <= cfg.enable_rotate;
            rd_sin   <= cfg.sin_theta;
            rd_cos   <= cfg.cos_theta;
            rd_state <= RD_HEADER;
         end else begin
            case (rd_state)
               RD_HEADER: rd_state <= RD_PIXELS;
               RD_PIXELS:
                  if (rd_pos == PIX_ADDR_W'(FRAME_PIXELS - 1))
                     rd_state <= RD_IDLE;
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge img_clk) begin
      if (cfg.frame_start)
         wr_meta <= in.meta;
      if (wr_last)
         rd_meta <= wr_meta;
   end

   // doubled coordinates 2 * pos - 15, so the centre sits on zero.
   assign dx = $signed({1'b0, rd_pos[COL_BITS-1:0], 1'b0}) - (COL_BITS+2)'(FRAME_COLS - 1);
   assign dy = $signed({1'b0, rd_pos[PIX_ADDR_W-1:COL_BITS], 1'b0}) -
               (ROW_BITS+2)'(FRAME_ROWS - 1);

   always_ff @(posedge img_clk or negedge rst_n) begin
      if (!rst_n) begin
         s1_dv <= 1'b0;
         s2_dv <= 1'b0;
         out.dv    <= 1'b0;
         out.dtype <= DTYPE_IDLE;
      end else begin
         s1_dv     <= (rd_state != RD_IDLE);
         s2_dv     <= s1_dv;
         out.dv    <= s2_dv;
         out.dtype <= s2_dv ? s2_dtype : DTYPE_IDLE;
      end
   end

   // stage 1, the four products.
   always_ff @(posedge img_clk) begin
      s1_dtype <= (rd_state == RD_HEADER) ? DTYPE_HEADER : DTYPE_PIXEL;
      s1_pos   <= rd_pos;
      s1_bank  <= rd_bank;
      s1_rot   <= rd_rot;
      s1_cx    <= rd_cos * dx;
      s1_sy    <= rd_sin * dy;
      s1_sx    <= rd_sin * dx;
      s1_cy    <= rd_cos * dy;
   end

   // stage 2, sums rounded to the nearest pixel.
   assign sum_x    = s1_cx + s1_sy + ROT_SUM_W'(ROT_BIAS);
   assign sum_y    = s1_cy - s1_sx + ROT_SUM_W'(ROT_BIAS);
   assign in_frame = (sum_x[ROT_SUM_W-1:ROT_SHIFT+COL_BITS] == '0) &&
                     (sum_y[ROT_SUM_W-1:ROT_SHIFT+ROW_BITS] == '0);

   always_ff @(posedge img_clk) begin
      s2_dtype  <= s1_dtype;
      s2_bank   <= s1_bank;
      s2_inside <= !s1_rot || in_frame;
      if (s1_rot)
         s2_addr <= {sum_y[ROT_SHIFT +: ROW_BITS], sum_x[ROT_SHIFT +: COL_BITS]};
      else
         s2_addr <= s1_pos;
   end

   // stage 3, memory read.
   always_ff @(posedge img_clk) begin
      rd_word   <= bank_mem[s2_bank][s2_addr];
      s3_inside <= s2_inside;
      out.meta  <= rd_meta;
   end

   assign out.y = s3_inside ? rd_word[3*BYTE_W-1 -: BYTE_W] : BLACK_Y;
   assign out.u = s3_inside ? rd_word[2*BYTE_W-1 -: BYTE_W] : BLACK_C;
   assign out.v = s3_inside ? rd_word[BYTE_W-1:0] : BLACK_C;

endmodule

// File: hw/pixel_packer.sv
module pixel_packer import rot_pkg::*; (
   input  logic        img_clk,
   input  logic        rst_n,
   pix_if.snk          in,
   rot_cfg_if.user     cfg,
   output logic        dvo,
   output dtype_e      dtypeo,
   output logic [31:0] datao
);

   logic                  is_hdr;
   logic                  is_pix;
   logic                  emit_pix;
   logic                  odd_col;
   logic                  odd_row;
   logic                  mode_420;
   logic [PIX_ADDR_W-1:0] pix_cnt;
   logic [BYTE_W-1:0]     y_even;
   logic [BYTE_W-1:0]     u_even;
   logic [BYTE_W-1:0]     v_even;

   assign is_hdr   = in.dv && (in.dtype == DTYPE_HEADER);
   assign is_pix   = in.dv && (in.dtype == DTYPE_PIXEL);
   assign odd_col  = pix_cnt[0];
   assign odd_row  = pix_cnt[COL_BITS];
   assign emit_pix = is_pix && (!mode_420 || odd_col); // 4:2:0 emits per pair.

   always_ff @(posedge img_clk or negedge rst_n) begin
      if (!rst_n) begin
         dvo      <= 1'b0;
         dtypeo   <= DTYPE_IDLE;
         mode_420 <= 1'b0;
         pix_cnt  <= '0;
      end else begin
         if (is_hdr) begin
            mode_420 <= cfg.enable_420; // held for the whole frame.
            pix_cnt  <= '0;
         end else if (is_pix) begin
            pix_cnt  <= pix_cnt + 1'b1;
         end
         dvo <= is_hdr || emit_pix;
         if (is_hdr)
            dtypeo <= DTYPE_HEADER;
         else if (emit_pix)
            dtypeo <= DTYPE_PIXEL;
         else
            dtypeo <= DTYPE_IDLE;
      end
   end

   always_ff @(posedge img_clk) begin
      if (is_pix && !odd_col) begin
         y_even <= in.y;
         u_even <= in.u;
         v_even <= in.v;
      end
      if (is_hdr)
         datao <= {{(32-META_WIDTH){1'b0}}, in.meta};
      else if (is_pix) begin
         if (!mode_420)
            datao <= {8'd0, in.y, in.u, in.v};
         else if (odd_row)
            datao <= {y_even, in.y, 16'd0}; // no chroma on odd rows.
         else
            datao <= {y_even, in.y, u_even, v_even};
      end
   end

endmodule

// File: hw/rotate_yuv420.sv
module rotate_yuv420 import rot_pkg::*; (
   input  logic                   img_clk,
   input  logic                   rst_n,
   input  logic [15:0]            di_term_addr,
   input  logic [31:0]            di_reg_addr,
   input  logic                   di_read,
   input  logic                   di_write,
   input  logic [31:0]            di_reg_datai,
   output logic                   di_read_rdy,
   output logic [31:0]            di_reg_datao,
   output logic                   di_write_rdy,
   output logic [15:0]            di_transfer_status,
   output logic                   di_en,
   input  logic                   dvi,
   input  dtype_e                 dtypei,
   input  logic [META_WIDTH-1:0]  meta_datai,
   input  logic [PIXEL_WIDTH-1:0] yi,
   input  logic [PIXEL_WIDTH-1:0] ui,
   input  logic [PIXEL_WIDTH-1:0] vi,
   output logic                   dvo,
   output dtype_e                 dtypeo,
   output logic [31:0]            datao
);

   pix_if               src_pix ();
   pix_if               off_pix ();
   pix_if #(.W(BYTE_W)) rot_pix (); // 8-bit samples after the frame memory.
   rot_cfg_if           cfg ();

   assign src_pix.dv    = dvi;
   assign src_pix.dtype = dtypei;
   assign src_pix.y     = yi;
   assign src_pix.u     = ui;
   assign src_pix.v     = vi;
   assign src_pix.meta  = meta_datai;

   reg_terminal term0 (
      .img_clk            (img_clk),
      .rst_n              (rst_n),
      .di_term_addr       (di_term_addr),
      .di_reg_addr        (di_reg_addr),
      .di_read            (di_read),
      .di_write           (di_write),
      .di_reg_datai       (di_reg_datai),
      .di_read_rdy        (di_read_rdy),
      .di_reg_datao       (di_reg_datao),
      .di_write_rdy       (di_write_rdy),
      .di_transfer_status (di_transfer_status),
      .di_en              (di_en),
      .cfg                (cfg.ctl)
   );

   uv_offset uv_offset0 (
      .img_clk (img_clk),
      .rst_n   (rst_n),
      .enable  (cfg.enable_420),
      .in      (src_pix.snk),
      .out     (off_pix.src)
   );

   rotate_buffer rotate0 (
      .img_clk (img_clk),
      .rst_n   (rst_n),
      .in      (off_pix.snk),
      .out     (rot_pix.src),
      .cfg     (cfg.user)
   );

   pixel_packer packer0 (
      .img_clk (img_clk),
      .rst_n   (rst_n),
      .in      (rot_pix.snk),
      .cfg     (cfg.user),
      .dvo     (dvo),
      .dtypeo  (dtypeo),
      .datao   (datao)
   );

endmodule

// File: sim/rotate_yuv420_props.sv
module rotate_yuv420_props import rot_pkg::*; (
   input logic                   img_clk,
   input logic                   rst_n,
   input logic [15:0]            di_term_addr,
   input logic [31:0]            di_reg_addr,
   input logic                   di_read,
   input logic                   di_write,
   input logic [31:0]            di_reg_datai,
   input logic                   di_read_rdy,
   input logic [31:0]            di_reg_datao,
   input logic                   di_write_rdy,
   input logic [15:0]            di_transfer_status,
   input logic                   di_en,
   input logic                   dvi,
   input dtype_e                 dtypei,
   input logic [META_WIDTH-1:0]  meta_datai,
   input logic [PIXEL_WIDTH-1:0] yi,
   input logic [PIXEL_WIDTH-1:0] ui,
   input logic [PIXEL_WIDTH-1:0] vi,
   input logic                   dvo,
   input dtype_e                 dtypeo,
   input logic [31:0]            datao
);

   int fail_cnt = 0;

   logic                          hit;
   logic [1:0]                    ctrl_w; // bit 0 rotate, bit 1 4:2:0.
   logic signed [ANGLE_WIDTH-1:0] sin_w;
   logic signed [ANGLE_WIDTH-1:0] cos_w;
   logic [1:0]                    ctrl_s;
   logic signed [ANGLE_WIDTH-1:0] sin_s;
   logic signed [ANGLE_WIDTH-1:0] cos_s;
   logic                          fs_seen;
   logic [META_WIDTH-1:0]         meta_s;
   logic [PIXEL_WIDTH-1:0]        u_in;
   logic [PIXEL_WIDTH-1:0]        v_in;
   logic                          hdr_seen;
   int                            frames;
   int                            in_cnt;
   int                            out_cnt;
   int                            frame_words;
   logic [3*BYTE_W-1:0]           src_mem [FRAME_PIXELS];

   assign hit  = (di_term_addr == TERM_ROTATE);
   assign u_in = ui + (ctrl_s[1] ? 10'd512 : 10'd0); // offset binary in 4:2:0 mode.
   assign v_in = vi + (ctrl_s[1] ? 10'd512 : 10'd0);

   function automatic logic [31:0] reg_value(input logic [31:0] addr);
      case (addr)
         REG_CTRL:   return {30'd0, ctrl_w};
         REG_SIN:    return {{(32-ANGLE_WIDTH){sin_w[ANGLE_WIDTH-1]}}, sin_w};
         REG_COS:    return {{(32-ANGLE_WIDTH){cos_w[ANGLE_WIDTH-1]}}, cos_w};
         REG_FRAMES: return 32'(frames);
         default:    return 32'd0;
      endcase
   endfunction

   // black stands in when the source of output position n falls off the frame.
   function automatic logic [3*BYTE_W-1:0] src_pixel(input int n);
      int dx;
      int dy;
      int sx;
      int sy;
      dx = 2 * (n % FRAME_COLS) - (FRAME_COLS - 1);
      dy = 2 * (n / FRAME_COLS) - (FRAME_ROWS - 1);
      if (!ctrl_s[0])
         return src_mem[n];
      // centre 7.5 plus half a pixel, then floor of the sum over 2 * ANGLE_ONE.
      sx = (int'(cos_s) * dx + int'(sin_s) * dy + FRAME_COLS * ANGLE_ONE) >>> 9;
      sy = (int'(cos_s) * dy - int'(sin_s) * dx + FRAME_ROWS * ANGLE_ONE) >>> 9;
      if (sx < 0 || sx >= FRAME_COLS || sy < 0 || sy >= FRAME_ROWS)
         return {BLACK_Y, BLACK_C, BLACK_C};
      return src_mem[sy * FRAME_COLS + sx];
   endfunction

   function automatic logic [31:0] expected_word(input int k);
      logic [3*BYTE_W-1:0] pe;
      logic [3*BYTE_W-1:0] po;
      if (!ctrl_s[1])
         return {8'd0, src_pixel(k)};
      pe = src_pixel(2 * k);
      po = src_pixel(2 * k + 1);
      if (((2 * k) / FRAME_COLS) % 2 == 1)
         return {pe[23:16], po[23:16], 16'd0}; // odd rows carry no chroma.
      return {pe[23:16], po[23:16], pe[15:0]};
   endfunction

   always @(posedge img_clk or negedge rst_n) begin
      if (!rst_n) begin
         ctrl_w   <= '0;
         sin_w    <= '0;
         cos_w    <= ANGLE_WIDTH'(ANGLE_ONE);
         ctrl_s   <= '0;
         sin_s    <= '0;
         cos_s    <= ANGLE_WIDTH'(ANGLE_ONE);
         fs_seen  <= 1'b0;
         hdr_seen <= 1'b0;
         frames   <= 0;
         in_cnt   <= 0;
         out_cnt  <= 0;
      end else begin
         fs_seen <= dvi && (dtypei == DTYPE_FRAME_START);
         if (di_write && hit) begin
            if (di_reg_addr == REG_CTRL)
               ctrl_w <= di_reg_datai[1:0];
            if (di_reg_addr == REG_SIN)
               sin_w <= di_reg_datai[ANGLE_WIDTH-1:0];
            if (di_reg_addr == REG_COS)
               cos_w <= di_reg_datai[ANGLE_WIDTH-1:0];
         end
         if (fs_seen) begin // shadow loads one beat after the frame start.
            ctrl_s <= ctrl_w;
            sin_s  <= sin_w;
            cos_s  <= cos_w;
         end
         if (dvi && dtypei == DTYPE_FRAME_START) begin
            frames <= frames + 1;
            in_cnt <= 0;
            meta_s <= meta_datai;
         end else if (dvi && dtypei == DTYPE_PIXEL) begin
            in_cnt <= in_cnt + 1;
         end
         if (dvo && dtypeo == DTYPE_HEADER) begin
            hdr_seen    <= 1'b1;
            out_cnt     <= 0;
            frame_words <= ctrl_s[1] ? FRAME_PIXELS / 2 : FRAME_PIXELS;
         end else if (dvo && dtypeo == DTYPE_PIXEL) begin
            out_cnt <= out_cnt + 1;
         end
      end
   end

   always @(posedge img_clk) begin
      if (dvi && dtypei == DTYPE_PIXEL && in_cnt < FRAME_PIXELS)
         src_mem[in_cnt] <= {yi[PIXEL_WIDTH-1 -: BYTE_W], u_in[PIXEL_WIDTH-1 -: BYTE_W],
                             v_in[PIXEL_WIDTH-1 -: BYTE_W]};
   end

   a_ready: assert property (@(posedge img_clk) disable iff (!rst_n)
      di_read_rdy && di_write_rdy)
      else begin
         fail_cnt++;
         $error("Fail at %0t: bus ready was dropped", $time);
      end

   a_hit: assert property (@(posedge img_clk) disable iff (!rst_n)
      hit |-> (di_transfer_status == 16'd0 && di_en))
      else begin
         fail_cnt++;
         $error("Fail at %0t: bad status on a terminal hit", $time);
      end

   a_miss: assert property (@(posedge img_clk) disable iff (!rst_n)
      !hit |-> (di_transfer_status == 16'd1 && !di_en && di_reg_datao == 32'd0))
      else begin
         fail_cnt++;
         $error("Fail at %0t: bad status or data on a terminal miss", $time);
      end

   a_read: assert property (@(posedge img_clk) disable iff (!rst_n)
      (hit && di_read) |-> (di_reg_datao == reg_value(di_reg_addr)))
      else begin
         fail_cnt++;
         $error("Fail at %0t: register %0d read %h", $time, di_reg_addr, di_reg_datao);
      end

   a_idle: assert property (@(posedge img_clk) disable iff (!rst_n)
      !dvo |-> (dtypeo == DTYPE_IDLE))
      else begin
         fail_cnt++;
         $error("Fail at %0t: dtypeo not idle while dvo is low", $time);
      end

   a_header: assert property (@(posedge img_clk) disable iff (!rst_n)
      (dvo && dtypeo == DTYPE_HEADER) |->
         (datao == {16'd0, meta_s} && (!hdr_seen || out_cnt == frame_words)))
      else begin
         fail_cnt++;
         $error("Fail at %0t: header %h after %0d words", $time, datao, out_cnt);
      end

   a_pixel: assert property (@(posedge img_clk) disable iff (!rst_n)
      (dvo && dtypeo == DTYPE_PIXEL) |->
         (hdr_seen && out_cnt < frame_words && datao == expected_word(out_cnt)))
      else begin
         fail_cnt++;
         $error("Fail at %0t: word %0d is %h, expected %h", $time, out_cnt, datao,
                expected_word(out_cnt));
      end

endmodule

// File: sim/rotate_yuv420_tb.sv
module rotate_yuv420_tb import rot_pkg::*; ();

   localparam int NUM_FRAMES     = 6;
   localparam int FRAME_CYCLES   = 3 * FRAME_PIXELS + 64; // all gaps taken plus read-out.
   localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_CYCLES + 400;

   logic                   img_clk;
   logic                   rst_n;
   logic [15:0]            di_term_addr;
   logic [31:0]            di_reg_addr;
   logic                   di_read;
   logic                   di_write;
   logic [31:0]            di_reg_datai;
   logic                   di_read_rdy;
   logic [31:0]            di_reg_datao;
   logic                   di_write_rdy;
   logic [15:0]            di_transfer_status;
   logic                   di_en;
   logic                   dvi;
   dtype_e                 dtypei;
   logic [META_WIDTH-1:0]  meta_datai;
   logic [PIXEL_WIDTH-1:0] yi;
   logic [PIXEL_WIDTH-1:0] ui;
   logic [PIXEL_WIDTH-1:0] vi;
   logic                   dvo;
   dtype_e                 dtypeo;
   logic [31:0]            datao;

   integer seed;
   int     tests_run;
   int     tests_bad;
   int     fails_seen;

   rotate_yuv420 dut0 (
      .img_clk            (img_clk),
      .rst_n              (rst_n),
      .di_term_addr       (di_term_addr),
      .di_reg_addr        (di_reg_addr),
      .di_read            (di_read),
      .di_write           (di_write),
      .di_reg_datai       (di_reg_datai),
      .di_read_rdy        (di_read_rdy),
      .di_reg_datao       (di_reg_datao),
      .di_write_rdy       (di_write_rdy),
      .di_transfer_status (di_transfer_status),
      .di_en              (di_en),
      .dvi                (dvi),
      .dtypei             (dtypei),
      .meta_datai         (meta_datai),
      .yi                 (yi),
      .ui                 (ui),
      .vi                 (vi),
      .dvo                (dvo),
      .dtypeo             (dtypeo),
      .datao              (datao)
   );

   bind rotate_yuv420 rotate_yuv420_props props0 (.*);

   initial begin
      img_clk = 1'b0;
      forever #50 img_clk = ~img_clk;
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge img_clk);
      $display("watchdog: run timed out after %0d cycles", TIMEOUT_CYCLES);
      $display("tests failed");
      $finish;
   end

   // one bus cycle, then the bus goes quiet again.
   task automatic bus_access(input logic [15:0] term, input logic [31:0] addr,
                             input logic rd, input logic wr, input logic [31:0] data);
      @(posedge img_clk);
      #10;
      di_term_addr = term;
      di_reg_addr  = addr;
      di_read      = rd;
      di_write     = wr;
      di_reg_datai = data;
      @(posedge img_clk);
      #10;
      di_read      = 1'b0;
      di_write     = 1'b0;
      di_term_addr = 16'h0000;
   endtask

   task automatic set_controls(input logic [31:0] ctrl, input logic [31:0] sin_v,
                               input logic [31:0] cos_v);
      bus_access(TERM_ROTATE, REG_CTRL, 1'b0, 1'b1, ctrl);
      bus_access(TERM_ROTATE, REG_SIN, 1'b0, 1'b1, sin_v);
      bus_access(TERM_ROTATE, REG_COS, 1'b0, 1'b1, cos_v);
   endtask

   task automatic send_frame(input logic [15:0] meta, input bit mid_write,
                             input logic [31:0] mid_sin, input logic [31:0] mid_cos);
      int row;
      int col;
      @(posedge img_clk);
      #10;
      dvi        = 1'b1;
      dtypei     = DTYPE_FRAME_START;
      meta_datai = meta;
      @(posedge img_clk);
      #10;
      dvi    = 1'b0; // one quiet beat so the shadow settles before pixel 0.
      dtypei = DTYPE_IDLE;
      @(posedge img_clk);
      #10;
      for (int n = 0; n < FRAME_PIXELS; n++) begin
         row = n / FRAME_COLS;
         col = n % FRAME_COLS;
         if (($random(seed) & 3) == 0) begin
            dvi    = 1'b0;
            dtypei = DTYPE_IDLE;
            @(posedge img_clk);
            #10;
         end
         dvi    = 1'b1;
         dtypei = DTYPE_PIXEL;
         yi     = {row[3:0], col[3:0], 2'b00};
         ui     = PIXEL_WIDTH'((col - 8) * 32);
         vi     = PIXEL_WIDTH'((row - 8) * 32);
         if (mid_write && n == 100) begin
            di_term_addr = TERM_ROTATE;
            di_reg_addr  = REG_SIN;
            di_write     = 1'b1;
            di_reg_datai = mid_sin;
         end else if (mid_write && n == 101) begin
            di_reg_addr  = REG_COS;
            di_reg_datai = mid_cos;
         end else if (n == 102) begin
            di_write     = 1'b0;
            di_term_addr = 16'h0000;
         end
         @(posedge img_clk);
         #10;
      end
      dvi    = 1'b0;
      dtypei = DTYPE_IDLE;
   endtask

   task automatic wait_readout(input int words);
      int seen;
      seen = 0;
      while (seen < words) begin
         @(negedge img_clk);
         if (dvo && dtypeo == DTYPE_PIXEL)
            seen++;
      end
      repeat (8) @(negedge img_clk); // room for any surplus word to show.
   endtask

   task automatic finish_test(input string name);
      int now_fails;
      now_fails = dut0.props0.fail_cnt;
      tests_run++;
      if (now_fails != fails_seen) begin
         tests_bad++;
         $display("Fail at %0t: %s, %0d assertion failures", $time, name,
                  now_fails - fails_seen);
      end else begin
         $display("ok at %0t: %s", $time, name);
      end
      fails_seen = now_fails;
   endtask

   initial begin
      seed         = 32'h66751d8f;
      tests_run    = 0;
      tests_bad    = 0;
      fails_seen   = 0;
      rst_n        = 1'b0;
      di_term_addr = 16'h0000;
      di_reg_addr  = 32'd0;
      di_read      = 1'b0;
      di_write     = 1'b0;
      di_reg_datai = 32'd0;
      dvi          = 1'b0;
      dtypei       = DTYPE_IDLE;
      meta_datai   = '0;
      yi           = '0;
      ui           = '0;
      vi           = '0;
      repeat (2) @(posedge img_clk);
      #10;
      rst_n = 1'b1;

      set_controls(32'd3, 32'hffff_fff0, 32'hffff_ff80);
      bus_access(TERM_ROTATE, REG_CTRL, 1'b1, 1'b0, 32'd0);
      bus_access(TERM_ROTATE, REG_SIN, 1'b1, 1'b0, 32'd0);
      bus_access(TERM_ROTATE, REG_COS, 1'b1, 1'b0, 32'd0);
      bus_access(16'h0020, REG_CTRL, 1'b0, 1'b1, 32'd0); // another terminal must not take it.
      bus_access(16'h0020, REG_CTRL, 1'b1, 1'b0, 32'd0);
      bus_access(TERM_ROTATE, REG_CTRL, 1'b1, 1'b0, 32'd0);
      finish_test("register access");

      set_controls(32'd0, 32'd0, ANGLE_ONE);
      send_frame(16'h1a01, 1'b0, 32'd0, 32'd0);
      wait_readout(FRAME_PIXELS);
      finish_test("identity");

      set_controls(32'd1, 32'd0, -ANGLE_ONE);
      send_frame(16'h1a02, 1'b0, 32'd0, 32'd0);
      wait_readout(FRAME_PIXELS);
      finish_test("rotate 180");

      // the late write to 180 degrees shows up only in the second frame.
      set_controls(32'd1, ANGLE_ONE, 32'd0);
      send_frame(16'h1a03, 1'b1, 32'd0, -ANGLE_ONE);
      wait_readout(FRAME_PIXELS);
      send_frame(16'h1a04, 1'b0, 32'd0, 32'd0);
      wait_readout(FRAME_PIXELS);
      finish_test("rotate 90 with mid-frame write");

      set_controls(32'd2, 32'd0, ANGLE_ONE);
      send_frame(16'h1a05, 1'b0, 32'd0, 32'd0);
      wait_readout(FRAME_PIXELS / 2);
      send_frame(16'h1a06, 1'b0, 32'd0, 32'd0);
      wait_readout(FRAME_PIXELS / 2);
      finish_test("4:2:0 with uv offset");

      bus_access(TERM_ROTATE, REG_FRAMES, 1'b1, 1'b0, 32'd0);
      finish_test("frame counter");

      $display("%0d tests run, %0d with failures, %0d assertion failures",
               tests_run, tests_bad, dut0.props0.fail_cnt);
      if (tests_bad == 0 && dut0.props0.fail_cnt == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

// File: vlog.f
hw/rot_pkg.sv
hw/pix_if.sv
hw/rot_cfg_if.sv
hw/reg_terminal.sv
hw/uv_offset.sv
hw/rotate_buffer.sv
hw/pixel_packer.sv
hw/rotate_yuv420.sv
sim/rotate_yuv420_props.sv
sim/rotate_yuv420_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
   --top-module rotate_yuv420_tb -f vlog.f

./obj_dir/Vrotate_yuv420_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
   exit 1
fi
grep -q "all tests passed" sim.log
